// ==== ped_gen_fetch.sv ====
`timescale 1ns/1ns

module ped_gen_fetch import ped_pkg::*; #(
    parameter int FIELD_SIZE = 253
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_fetch_start,
    input  logic [5:0]            i_step,
    input  logic                  i_cfg_valid,
    input  logic [255:0]          i_cfg_data,
    output logic                  o_cfg_req,
    output logic [31:0]           o_cfg_addr,
    output logic                  o_pt_vld,
    output logic [FIELD_SIZE-1:0] o_pt_x,
    output logic [FIELD_SIZE-1:0] o_pt_y
);

    localparam logic [1:0] F_IDLE   = 2'd0;
    localparam logic [1:0] F_WAIT_X = 2'd1;
    localparam logic [1:0] F_WAIT_Y = 2'd2;

    logic [1:0] state;
    logic [5:0] step_q;
    logic [7:0] idx_x;
    logic [7:0] idx_y;

    // x at 2k, y at 2k+1
    assign idx_x = {1'b0, i_step, 1'b0};
    assign idx_y = {1'b0, step_q, 1'b1};

    // ============================================================
    // read sequencer
    // ============================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state     <= F_IDLE;
            o_cfg_req <= 1'b0;
            o_pt_vld  <= 1'b0;
        end else begin
            o_cfg_req <= 1'b0;
            o_pt_vld  <= 1'b0;
            case (state)
                F_IDLE: begin
                    if (i_fetch_start) begin
                        o_cfg_req <= 1'b1;
                        state     <= F_WAIT_X;
                    end
                end
                F_WAIT_X: begin
                    if (i_cfg_valid) begin
                        o_cfg_req <= 1'b1; // y read right behind x
                        state     <= F_WAIT_Y;
                    end
                end
                F_WAIT_Y: begin
                    if (i_cfg_valid) begin
                        o_pt_vld <= 1'b1;
                        state    <= F_IDLE;
                    end
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    // address and coordinate words
    always_ff @(posedge i_clk) begin
        if (state == F_IDLE && i_fetch_start) begin
            step_q     <= i_step;
            o_cfg_addr <= {PED_STORE_ID, 8'h00, idx_x};
        end
        if (state == F_WAIT_X && i_cfg_valid) begin
            o_pt_x     <= i_cfg_data[FIELD_SIZE-1:0];
            o_cfg_addr <= {PED_STORE_ID, 8'h00, idx_y};
        end
        if (state == F_WAIT_Y && i_cfg_valid)
            o_pt_y <= i_cfg_data[FIELD_SIZE-1:0];
    end

endmodule

// ==== ped_padder.sv ====
`timescale 1ns/1ns

module ped_padder import ped_pkg::*; (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_vld,
    input  logic [31:0] i_a,
    input  logic [2:0]  i_mode,
    input  logic        i_done,
    output logic        o_rdy,
    output logic        o_word_vld,
    output ped_padded_t o_word
);

    logic        accept;
    logic        busy;
    logic        busy_nxt;
    logic [7:0]  mode_code;
    logic [15:0] size_code;
    logic [31:0] payload_mask;
    ped_padded_t word_nxt;

    assign accept   = i_vld && o_rdy;
    assign busy_nxt = accept ? 1'b1 : (i_done ? 1'b0 : busy);

    // selector decode
    always_comb begin
        mode_code    = 8'h00;
        size_code    = 16'h0000;
        payload_mask = 32'h0000_0000;
        case (i_mode)
            SEL_U8: begin
                mode_code    = MODE_U8;
                size_code    = SIZE_8;
                payload_mask = 32'h0000_00ff;
            end
            SEL_U16: begin
                mode_code    = MODE_U16;
                size_code    = SIZE_16;
                payload_mask = 32'h0000_ffff;
            end
            SEL_U32: begin
                mode_code    = MODE_U32;
                size_code    = SIZE_32;
                payload_mask = 32'hffff_ffff;
            end
            SEL_I8: begin
                mode_code    = MODE_I8;
                size_code    = SIZE_8;
                payload_mask = 32'h0000_00ff;
            end
            SEL_I16: begin
                mode_code    = MODE_I16;
                size_code    = SIZE_16;
                payload_mask = 32'h0000_ffff;
            end
            SEL_I32: begin
                mode_code    = MODE_I32;
                size_code    = SIZE_32;
                payload_mask = 32'hffff_ffff;
            end
            default: ; // unlisted -> all zero word
        endcase
    end

    always_comb begin
        word_nxt.f.fill_payload = {6'd0, i_a & payload_mask};
        word_nxt.f.size         = size_code;
        word_nxt.f.mode         = mode_code;
        word_nxt.f.head         = 2'b00;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy       <= 1'b0;
            o_rdy      <= 1'b0;
            o_word_vld <= 1'b0;
        end else begin
            busy       <= busy_nxt;
            o_rdy      <= !busy_nxt; // first rise one cycle out of reset
            o_word_vld <= accept;
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept)
            o_word <= word_nxt;
    end

endmodule

// ==== ped_pkg.sv ====
package ped_pkg;

    // ============================================================
    // padded word layout
    // ============================================================
    typedef struct packed {
        logic [37:0] fill_payload; // payload low, zeros above
        logic [15:0] size;
        logic [7:0]  mode;
        logic [1:0]  head;         // always zero
    } ped_fields_t;

    // scanned bit by bit, built field by field
    typedef union packed {
        logic [63:0] vec;
        ped_fields_t f;
    } ped_padded_t;

    // ============================================================
    // mode codes and sizes
    // ============================================================
    localparam logic [7:0] MODE_I8  = 8'h04;
    localparam logic [7:0] MODE_I16 = 8'h05;
    localparam logic [7:0] MODE_I32 = 8'h06;
    localparam logic [7:0] MODE_U8  = 8'h09;
    localparam logic [7:0] MODE_U16 = 8'h0a;
    localparam logic [7:0] MODE_U32 = 8'h0b;

    localparam logic [15:0] SIZE_8  = 16'd8;
    localparam logic [15:0] SIZE_16 = 16'd16;
    localparam logic [15:0] SIZE_32 = 16'd32;

    // i_mode encodings
    localparam logic [2:0] SEL_U8  = 3'b000;
    localparam logic [2:0] SEL_U16 = 3'b001;
    localparam logic [2:0] SEL_U32 = 3'b010;
    localparam logic [2:0] SEL_I8  = 3'b100;
    localparam logic [2:0] SEL_I16 = 3'b101;
    localparam logic [2:0] SEL_I32 = 3'b110;

    localparam logic [15:0] PED_STORE_ID = 16'h0a51; // upper half of store address
    localparam logic [5:0]  PED_STEPS    = 6'd63;    // bits 1..63

endpackage

// ==== ped_properties.sv ====
`timescale 1ns/1ns

module ped_properties #(
    parameter int FIELD_SIZE = 253
) (
    input logic                  i_clk,
    input logic                  i_rst_n,
    input logic                  i_rdy,
    input logic                  i_res_vld,
    input logic [FIELD_SIZE-1:0] i_res,
    input logic                  i_res_rdy,
    input logic                  i_cfg_req,
    input logic                  i_cfg_valid,
    input logic                  i_add_vld
);

    logic cfg_pending; // store read out, no answer yet

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n)
            cfg_pending <= 1'b0;
        else if (i_cfg_req)
            cfg_pending <= 1'b1;
        else if (i_cfg_valid)
            cfg_pending <= 1'b0;
    end

    add_single_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_add_vld |=> !i_add_vld)
        else $error("add request held longer than one cycle");

    cfg_one_outstanding: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_cfg_req |-> !cfg_pending)
        else $error("store read issued before the previous answer");

    res_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_res_vld && !i_res_rdy) |=> (i_res_vld && $stable(i_res)))
        else $error("result changed or dropped while not taken");

    rdy_res_exclusive: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_rdy && i_res_vld))
        else $error("request ready while a result is held");

endmodule

bind ped_top ped_properties #(
    .FIELD_SIZE (FIELD_SIZE)
) u_properties (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_rdy       (o_rdy),
    .i_res_vld   (o_res_vld),
    .i_res       (o_res),
    .i_res_rdy   (i_res_rdy),
    .i_cfg_req   (o_cfg_req),
    .i_cfg_valid (i_cfg_valid),
    .i_add_vld   (o_add_vld)
);

// ==== ped_scan_ctrl.sv ====
`timescale 1ns/1ns

module ped_scan_ctrl import ped_pkg::*; #(
    parameter int FIELD_SIZE = 253
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_word_vld,
    input  ped_padded_t           i_word,
    input  logic                  i_pt_vld,
    input  logic [FIELD_SIZE-1:0] i_pt_x,
    input  logic [FIELD_SIZE-1:0] i_pt_y,
    input  logic                  i_add_res_vld,
    input  logic [FIELD_SIZE-1:0] i_add_res_x,
    input  logic [FIELD_SIZE-1:0] i_add_res_y,
    input  logic                  i_res_rdy,
    output logic                  o_fetch_start,
    output logic [5:0]            o_step,
    output logic                  o_add_vld,
    output logic [FIELD_SIZE-1:0] o_add_a_x,
    output logic [FIELD_SIZE-1:0] o_add_a_y,
    output logic [FIELD_SIZE-1:0] o_add_b_x,
    output logic [FIELD_SIZE-1:0] o_add_b_y,
    output logic                  o_res_vld,
    output logic [FIELD_SIZE-1:0] o_res,
    output logic                  o_done
);

    localparam logic [2:0] S_IDLE  = 3'd0;
    localparam logic [2:0] S_JUDGE = 3'd1;
    localparam logic [2:0] S_FETCH = 3'd2;
    localparam logic [2:0] S_ADD   = 3'd3;
    localparam logic [2:0] S_WAIT  = 3'd4;
    localparam logic [2:0] S_HOLD  = 3'd5;

    localparam logic [FIELD_SIZE-1:0] COORD_ONE = {{(FIELD_SIZE-1){1'b0}}, 1'b1};

    logic [2:0]            state;
    logic [5:0]            step;
    logic                  cur_bit;
    logic                  last_step;
    ped_padded_t           word_q;
    logic [FIELD_SIZE-1:0] acc_x;
    logic [FIELD_SIZE-1:0] acc_y;
    logic [FIELD_SIZE-1:0] add_b_x;
    logic [FIELD_SIZE-1:0] add_b_y;

    assign cur_bit   = word_q.vec[step];
    assign last_step = (step == PED_STEPS);

    assign o_step    = step;
    assign o_add_a_x = acc_x;
    assign o_add_a_y = acc_y;
    assign o_add_b_x = add_b_x;
    assign o_add_b_y = add_b_y;

    // ============================================================
    // step sequencer
    // ============================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state         <= S_IDLE;
            step          <= 6'd0;
            o_fetch_start <= 1'b0;
            o_add_vld     <= 1'b0;
            o_res_vld     <= 1'b0;
            o_done        <= 1'b0;
        end else begin
            o_fetch_start <= 1'b0;
            o_add_vld     <= 1'b0;
            o_done        <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (i_word_vld) begin
                        step  <= 6'd1; // head bit 0 is never scanned
                        state <= S_JUDGE;
                    end
                end
                S_JUDGE: begin
                    if (cur_bit) begin
                        o_fetch_start <= 1'b1;
                        state         <= S_FETCH;
                    end else begin
                        state <= S_ADD;
                    end
                end
                S_FETCH: begin
                    if (i_pt_vld)
                        state <= S_ADD;
                end
                S_ADD: begin
                    o_add_vld <= 1'b1;
                    state     <= S_WAIT;
                end
                S_WAIT: begin
                    if (i_add_res_vld) begin
                        if (last_step) begin
                            o_res_vld <= 1'b1;
                            state     <= S_HOLD;
                        end else begin
                            step  <= step + 6'd1;
                            state <= S_JUDGE;
                        end
                    end
                end
                S_HOLD: begin
                    if (i_res_rdy) begin
                        o_res_vld <= 1'b0;
                        o_done    <= 1'b1; // frees the padder
                        state     <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // ============================================================
    // accumulator, addend, result
    // ============================================================
    always_ff @(posedge i_clk) begin
        if (state == S_IDLE && i_word_vld) begin
            word_q <= i_word;
            acc_x  <= '0;        // identity point
            acc_y  <= COORD_ONE;
        end
        if (state == S_JUDGE && !cur_bit) begin
            add_b_x <= '0;
            add_b_y <= COORD_ONE;
        end
        if (state == S_FETCH && i_pt_vld) begin
            add_b_x <= i_pt_x;
            add_b_y <= i_pt_y;
        end
        if (state == S_WAIT && i_add_res_vld) begin
            acc_x <= i_add_res_x;
            acc_y <= i_add_res_y;
            if (last_step)
                o_res <= i_add_res_x; // held through S_HOLD
        end
    end

endmodule

// ==== ped_tb.sv ====
`timescale 1ns/1ns

module ped_tb import ped_pkg::*; ();

    localparam int FS          = 253;
    localparam int CLK_PERIOD  = 4;
    localparam int NUM_REQ     = 40;
    localparam int WATCHDOG_NS = NUM_REQ * 63 * 40 * CLK_PERIOD;

    localparam logic [31:0]   LFSR_TAPS = 32'hb4bc_d35c;
    localparam logic [FS-1:0] ONE       = {{(FS-1){1'b0}}, 1'b1};

    logic          clk = 1'b0;
    logic          rst_n;
    logic          req_vld;
    logic [31:0]   req_a;
    logic [2:0]    req_mode;
    logic          req_rdy;
    logic          res_rdy;
    logic          res_vld;
    logic [FS-1:0] res;
    logic          cfg_req;
    logic [31:0]   cfg_addr;
    logic          cfg_valid;
    logic [255:0]  cfg_data;
    logic          add_vld;
    logic [FS-1:0] add_a_x;
    logic [FS-1:0] add_a_y;
    logic [FS-1:0] add_b_x;
    logic [FS-1:0] add_b_y;
    logic          add_res_vld;
    logic [FS-1:0] add_res_x;
    logic [FS-1:0] add_res_y;

    logic [255:0]  store_mem [256];
    ped_padded_t   exp_word;
    logic [FS-1:0] exp_res;
    logic [31:0]   exp_addr_q [$];
    logic [FS-1:0] exp_ax_q [$];
    logic [FS-1:0] exp_ay_q [$];
    logic [FS-1:0] exp_bx_q [$];
    logic [FS-1:0] exp_by_q [$];
    int            err_value = 0;
    int            err_other = 0;

    ped_top #(
        .FIELD_SIZE (FS)
    ) u_ped_top (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_vld         (req_vld),
        .i_a           (req_a),
        .i_mode        (req_mode),
        .o_rdy         (req_rdy),
        .i_res_rdy     (res_rdy),
        .o_res_vld     (res_vld),
        .o_res         (res),
        .o_cfg_req     (cfg_req),
        .o_cfg_addr    (cfg_addr),
        .i_cfg_valid   (cfg_valid),
        .i_cfg_data    (cfg_data),
        .o_add_vld     (add_vld),
        .o_add_a_x     (add_a_x),
        .o_add_a_y     (add_a_y),
        .o_add_b_x     (add_b_x),
        .o_add_b_y     (add_b_y),
        .i_add_res_vld (add_res_vld),
        .i_add_res_x   (add_res_x),
        .i_add_res_y   (add_res_y)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ============================================================
    // random source and compare tasks
    // ============================================================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    task automatic draw_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v  = {v[30:0], st[0]}; // one step per bit
            st = lfsr_next(st);
        end
    endtask

    task automatic check_word(input ped_padded_t got, input ped_padded_t exp);
        if (got !== exp) begin
            err_value++;
            $display("FAILED %0t: padded word got %h exp %h", $time, got.vec, exp.vec);
        end
    endtask

    task automatic check_coord(input string what, input logic [FS-1:0] got,
                               input logic [FS-1:0] exp);
        if (got !== exp) begin
            err_value++;
            $display("FAILED %0t: %s got %h exp %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            err_value++;
            $display("FAILED %0t: store address got %h exp %h", $time, got, exp);
        end
    endtask

    task automatic report_other(input string msg);
        err_other++;
        $display("ERROR %0t: %s", $time, msg);
    endtask

    // ============================================================
    // reference model
    // ============================================================
    function automatic ped_padded_t pad_model(input logic [31:0] a, input logic [2:0] sel);
        ped_padded_t w;
        int          nbits;
        w.vec = '0;
        case (sel)
            SEL_U8, SEL_I8:   nbits = 8;
            SEL_U16, SEL_I16: nbits = 16;
            SEL_U32, SEL_I32: nbits = 32;
            default:          nbits = 0;
        endcase
        case (sel)
            SEL_U8:  w.f.mode = MODE_U8;
            SEL_U16: w.f.mode = MODE_U16;
            SEL_U32: w.f.mode = MODE_U32;
            SEL_I8:  w.f.mode = MODE_I8;
            SEL_I16: w.f.mode = MODE_I16;
            SEL_I32: w.f.mode = MODE_I32;
            default: w.f.mode = 8'h00;
        endcase
        if (nbits != 0) begin
            w.f.size         = 16'(nbits);
            w.f.fill_payload = 38'({1'b0, a} & ((33'd1 << nbits) - 33'd1));
        end
        return w;
    endfunction

    task automatic run_model(input logic [31:0] a, input logic [2:0] sel);
        logic [FS-1:0] ax;
        logic [FS-1:0] ay;
        logic [FS-1:0] bx;
        logic [FS-1:0] by;
        logic [5:0]    kb;
        int            k;
        exp_word = pad_model(a, sel);
        ax = '0;
        ay = ONE;
        for (k = 1; k <= 63; k++) begin
            kb = 6'(k);
            if (exp_word.vec[kb]) begin
                bx = store_mem[{1'b0, kb, 1'b0}][FS-1:0];
                by = store_mem[{1'b0, kb, 1'b1}][FS-1:0];
                exp_addr_q.push_back({PED_STORE_ID, 8'h00, 1'b0, kb, 1'b0});
                exp_addr_q.push_back({PED_STORE_ID, 8'h00, 1'b0, kb, 1'b1});
            end else begin
                bx = '0; // identity addend
                by = ONE;
            end
            exp_ax_q.push_back(ax);
            exp_ay_q.push_back(ay);
            exp_bx_q.push_back(bx);
            exp_by_q.push_back(by);
            ax = ax + bx;
            ay = ay + by;
        end
        exp_res = ax;
    endtask

    // ============================================================
    // store and adder models
    // ============================================================
    initial begin : store_model
        logic [31:0] st;
        logic [31:0] r;
        int          dly;
        st        = 32'd53269;
        cfg_valid = 1'b0;
        cfg_data  = '0;
        forever begin
            @(negedge clk);
            cfg_valid = 1'b0;
            if (cfg_req) begin
                if (exp_addr_q.size() == 0)
                    report_other("store read issued with no read expected");
                else
                    check_addr(cfg_addr, exp_addr_q.pop_front());
                draw_bits(st, 3, r);
                dly = 1 + int'(r % 32'd6);
                repeat (dly) @(negedge clk);
                cfg_data  = store_mem[cfg_addr[7:0]];
                cfg_valid = 1'b1;
            end
        end
    end

    initial begin : adder_model
        logic [31:0]   st;
        logic [31:0]   r;
        logic [FS-1:0] sum_x;
        logic [FS-1:0] sum_y;
        int            dly;
        st          = 32'd53269;
        add_res_vld = 1'b0;
        add_res_x   = '0;
        add_res_y   = '0;
        forever begin
            @(negedge clk);
            add_res_vld = 1'b0;
            if (add_vld) begin
                if (exp_ax_q.size() == 0) begin
                    report_other("add request issued beyond the 63 steps");
                end else begin
                    check_coord("add a_x", add_a_x, exp_ax_q.pop_front());
                    check_coord("add a_y", add_a_y, exp_ay_q.pop_front());
                    check_coord("add b_x", add_b_x, exp_bx_q.pop_front());
                    check_coord("add b_y", add_b_y, exp_by_q.pop_front());
                end
                draw_bits(st, 3, r);
                dly = 1 + int'(r % 32'd6);
                repeat (dly) @(negedge clk);
                sum_x = add_a_x + add_b_x; // wraps at FS bits
                sum_y = add_a_y + add_b_y;
                add_res_x   = sum_x;
                add_res_y   = sum_y;
                add_res_vld = 1'b1;
            end
        end
    end

    initial begin : word_monitor
        forever begin
            @(negedge clk);
            if (u_ped_top.word_vld)
                check_word(u_ped_top.word, exp_word);
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog timeout after %0d ns, the DUT stopped making progress", WATCHDOG_NS);
        $display("tests failed");
        $finish;
    end

    // ============================================================
    // stimulus
    // ============================================================
    initial begin : stimulus
        logic [31:0]   main_lfsr;
        logic [31:0]   r;
        logic [255:0]  w;
        int            n;
        int            j;
        main_lfsr = 32'd53269;
        rst_n     = 1'b0;
        req_vld   = 1'b0;
        req_a     = '0;
        req_mode  = SEL_U8;
        res_rdy   = 1'b0;
        w         = '0;
        for (n = 0; n < 256; n++) begin
            for (j = 0; j < 8; j++) begin
                draw_bits(main_lfsr, 32, r);
                w = {w[223:0], r};
            end
            store_mem[8'(n)] = w;
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        for (n = 0; n < NUM_REQ; n++) begin
            while (!req_rdy) @(negedge clk);
            draw_bits(main_lfsr, 32, r);
            req_a = r;
            case (n % 6)
                0:       req_mode = SEL_U8;
                1:       req_mode = SEL_U16;
                2:       req_mode = SEL_U32;
                3:       req_mode = SEL_I8;
                4:       req_mode = SEL_I16;
                default: req_mode = SEL_I32;
            endcase
            run_model(req_a, req_mode);
            req_vld = 1'b1;
            @(negedge clk);

            // extra requests while busy are dropped
            draw_bits(main_lfsr, 3, r);
            req_a    = ~req_a;
            req_mode = SEL_U32;
            repeat (int'(r[2:0])) begin
                if (req_rdy)
                    report_other("o_rdy high while a request is in progress");
                @(negedge clk);
            end
            req_vld = 1'b0;

            while (!res_vld) @(negedge clk);
            check_coord("result", res, exp_res);
            draw_bits(main_lfsr, 4, r);
            repeat (int'(r[3:0])) begin
                @(negedge clk);
                if (!res_vld)
                    report_other("o_res_vld dropped before the result was taken");
                if (req_rdy)
                    report_other("o_rdy high while a result is held");
                check_coord("held result", res, exp_res);
            end
            res_rdy = 1'b1;
            @(negedge clk);
            res_rdy = 1'b0;
            if (exp_addr_q.size() != 0)
                report_other("store reads missing for this request");
            if (exp_ax_q.size() != 0)
                report_other("add requests missing for this request");
        end

        repeat (4) @(negedge clk);
        $display("errors: %0d value, %0d other", err_value, err_other);
        if (err_value == 0 && err_other == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== ped_top.sv ====
`timescale 1ns/1ns

module ped_top import ped_pkg::*; #(
    parameter int FIELD_SIZE = 253
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,

    // request side
    input  logic                  i_vld,
    input  logic [31:0]           i_a,
    input  logic [2:0]            i_mode,
    output logic                  o_rdy,

    // result side
    input  logic                  i_res_rdy,
    output logic                  o_res_vld,
    output logic [FIELD_SIZE-1:0] o_res,

    // configuration store
    output logic                  o_cfg_req,
    output logic [31:0]           o_cfg_addr,
    input  logic                  i_cfg_valid,
    input  logic [255:0]          i_cfg_data,

    // external point adder
    output logic                  o_add_vld,
    output logic [FIELD_SIZE-1:0] o_add_a_x,
    output logic [FIELD_SIZE-1:0] o_add_a_y,
    output logic [FIELD_SIZE-1:0] o_add_b_x,
    output logic [FIELD_SIZE-1:0] o_add_b_y,
    input  logic                  i_add_res_vld,
    input  logic [FIELD_SIZE-1:0] i_add_res_x,
    input  logic [FIELD_SIZE-1:0] i_add_res_y
);

    ped_padded_t           word;
    logic                  word_vld;
    logic                  done;
    logic                  fetch_start;
    logic [5:0]            step;
    logic                  pt_vld;
    logic [FIELD_SIZE-1:0] pt_x;
    logic [FIELD_SIZE-1:0] pt_y;

    ped_padder u_padder (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_vld      (i_vld),
        .i_a        (i_a),
        .i_mode     (i_mode),
        .i_done     (done),
        .o_rdy      (o_rdy),
        .o_word_vld (word_vld),
        .o_word     (word)
    );

    ped_gen_fetch #(
        .FIELD_SIZE (FIELD_SIZE)
    ) u_gen_fetch (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_fetch_start (fetch_start),
        .i_step        (step),
        .i_cfg_valid   (i_cfg_valid),
        .i_cfg_data    (i_cfg_data),
        .o_cfg_req     (o_cfg_req),
        .o_cfg_addr    (o_cfg_addr),
        .o_pt_vld      (pt_vld),
        .o_pt_x        (pt_x),
        .o_pt_y        (pt_y)
    );

    ped_scan_ctrl #(
        .FIELD_SIZE (FIELD_SIZE)
    ) u_scan_ctrl (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_word_vld    (word_vld),
        .i_word        (word),
        .i_pt_vld      (pt_vld),
        .i_pt_x        (pt_x),
        .i_pt_y        (pt_y),
        .i_add_res_vld (i_add_res_vld),
        .i_add_res_x   (i_add_res_x),
        .i_add_res_y   (i_add_res_y),
        .i_res_rdy     (i_res_rdy),
        .o_fetch_start (fetch_start),
        .o_step        (step),
        .o_add_vld     (o_add_vld),
        .o_add_a_x     (o_add_a_x),
        .o_add_a_y     (o_add_a_y),
        .o_add_b_x     (o_add_b_x),
        .o_add_b_y     (o_add_b_y),
        .o_res_vld     (o_res_vld),
        .o_res         (o_res),
        .o_done        (done)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -j 0 --top-module ped_tb -f sources.f -o ped_sim
./obj_dir/ped_sim | tee sim.log

if grep -qx "all tests passed" sim.log; then
    echo "simulation PASSED"
else
    echo "simulation FAILED"
    exit 1
fi

// ==== sources.f ====
ped_pkg.sv
ped_padder.sv
ped_gen_fetch.sv
ped_scan_ctrl.sv
ped_top.sv
ped_properties.sv
ped_tb.sv
